//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// boot vector
`define RESET_PC 32'hbfc0_0000

// primary opcodes
`define OP_RTYPE 6'b000000
`define OP_ADDIU 6'b001001
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_J     6'b000010

// R-type function codes
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_SLT   6'b101010

`define NUM_REGS 32

`endif

//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;     // data or address word
    typedef logic [4:0]  regAddr_t;  // register number
    typedef logic [5:0]  opcode_t;   // instr[31:26]
    typedef logic [5:0]  funct_t;    // instr[5:0] of R-type
    typedef logic [15:0] imm_t;      // raw immediate field

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_t;

    // decode operand source
    typedef enum logic [1:0] {
        FWD_REG,   // register file
        FWD_EXEC,  // ALU result in execute
        FWD_MEM,   // memory stage result, load data included
        FWD_WB     // value being written back
    } fwdSel_t;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire cpu_pkg::aluOp_t  aluOp_i,
    input  wire cpu_pkg::word_t   srcA_i,
    input  wire cpu_pkg::word_t   srcB_i,
    input  wire cpu_pkg::word_t   rsVal_i,
    input  wire cpu_pkg::word_t   rtVal_i,
    input  wire                   branch_i,
    input  wire                   branchNe_i,
    output cpu_pkg::word_t        result_o,
    output logic                  branchTaken_o
);
    import cpu_pkg::*;

    logic isLess;
    logic isEqual;

    assign isLess  = $signed(srcA_i) < $signed(srcB_i);
    assign isEqual = (rsVal_i == rtVal_i);

    always_comb begin
        case (aluOp_i)
            ALU_ADD: result_o = srcA_i + srcB_i;  // wraps, no overflow trap
            ALU_SUB: result_o = srcA_i - srcB_i;
            ALU_AND: result_o = srcA_i & srcB_i;
            ALU_OR:  result_o = srcA_i | srcB_i;
            ALU_XOR: result_o = srcA_i ^ srcB_i;
            ALU_SLT: result_o = {31'd0, isLess};
            default: result_o = srcA_i + srcB_i;
        endcase
    end

    assign branchTaken_o = branch_i && (branchNe_i ? !isEqual : isEqual);

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_unit (
    input  wire cpu_pkg::regAddr_t  rsD_i,
    input  wire cpu_pkg::regAddr_t  rtD_i,
    input  wire                     readsRs_i,
    input  wire                     readsRt_i,
    input  wire cpu_pkg::regAddr_t  destE_i,
    input  wire cpu_pkg::regAddr_t  destM_i,
    input  wire cpu_pkg::regAddr_t  destW_i,
    input  wire                     regWriteE_i,
    input  wire                     regWriteM_i,
    input  wire                     regWriteW_i,
    input  wire                     memReadE_i,
    input  wire                     branchTakenE_i,
    output cpu_pkg::fwdSel_t        fwdA_o,
    output cpu_pkg::fwdSel_t        fwdB_o,
    output logic                    stallFd_o,
    output logic                    flushD_o,
    output logic                    flushE_o
);
    import cpu_pkg::*;

    logic loadHitRs;
    logic loadHitRt;

    // youngest writer wins, r0 never forwarded
    function automatic fwdSel_t pickSource(input regAddr_t src);
        fwdSel_t sel;
        if (src == '0) begin
            sel = FWD_REG;
        end else if (regWriteE_i && destE_i == src) begin
            sel = FWD_EXEC;
        end else if (regWriteM_i && destM_i == src) begin
            sel = FWD_MEM;
        end else if (regWriteW_i && destW_i == src) begin
            sel = FWD_WB;
        end else begin
            sel = FWD_REG;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA_o = pickSource(rsD_i);
        fwdB_o = pickSource(rtD_i);
    end

    // load data only exists one stage later
    assign loadHitRs = readsRs_i && (rsD_i == destE_i);
    assign loadHitRt = readsRt_i && (rtD_i == destE_i);
    assign stallFd_o = memReadE_i && regWriteE_i && (destE_i != '0)
                       && (loadHitRs || loadHitRt);

    assign flushE_o = stallFd_o;       // bubble behind the load
    assign flushD_o = branchTakenE_i;  // wrong-path fetch after the slot

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module inst_decoder (
    input  wire cpu_pkg::word_t  instr_i,
    output cpu_pkg::aluOp_t      aluOp_o,
    output logic                 useImm_o,
    output logic                 regWrite_o,
    output cpu_pkg::regAddr_t    destReg_o,
    output logic                 memRead_o,
    output logic                 memWrite_o,
    output logic                 branch_o,
    output logic                 branchNe_o,
    output logic                 jump_o,
    output logic                 readsRs_o,
    output logic                 readsRt_o
);
    import cpu_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rt;
    regAddr_t rd;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign rt     = instr_i[20:16];
    assign rd     = instr_i[15:11];

    always_comb begin
        aluOp_o    = ALU_ADD;  // address and immediate adds
        useImm_o   = 1'b0;
        regWrite_o = 1'b0;
        destReg_o  = '0;
        memRead_o  = 1'b0;
        memWrite_o = 1'b0;
        branch_o   = 1'b0;
        branchNe_o = 1'b0;
        jump_o     = 1'b0;
        readsRs_o  = 1'b0;
        readsRt_o  = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                destReg_o  = rd;
                regWrite_o = 1'b1;
                readsRs_o  = 1'b1;
                readsRt_o  = 1'b1;
                case (funct)
                    `FN_ADDU: aluOp_o = ALU_ADD;
                    `FN_SUBU: aluOp_o = ALU_SUB;
                    `FN_AND:  aluOp_o = ALU_AND;
                    `FN_OR:   aluOp_o = ALU_OR;
                    `FN_XOR:  aluOp_o = ALU_XOR;
                    `FN_SLT:  aluOp_o = ALU_SLT;
                    default: begin
                        // sll and the rest fall through as nops
                        regWrite_o = 1'b0;
                        readsRs_o  = 1'b0;
                        readsRt_o  = 1'b0;
                    end
                endcase
            end
            `OP_ADDIU: begin
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                destReg_o  = rt;
                readsRs_o  = 1'b1;
            end
            `OP_LW: begin
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                destReg_o  = rt;
                memRead_o  = 1'b1;
                readsRs_o  = 1'b1;
            end
            `OP_SW: begin
                useImm_o   = 1'b1;
                memWrite_o = 1'b1;
                readsRs_o  = 1'b1;
                readsRt_o  = 1'b1;  // store data
            end
            `OP_BEQ, `OP_BNE: begin
                branch_o   = 1'b1;
                branchNe_o = (opcode == `OP_BNE);
                readsRs_o  = 1'b1;
                readsRt_o  = 1'b1;
            end
            `OP_J:   jump_o = 1'b1;
            default: ;  // unknown opcode, nop
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module pc_unit (
    input  wire                  clk,
    input  wire                  reset_i,
    input  wire                  stall_i,
    input  wire                  jump_i,
    input  wire cpu_pkg::word_t  jumpTarget_i,
    input  wire                  branchTaken_i,
    input  wire cpu_pkg::word_t  branchTarget_i,
    output cpu_pkg::word_t       pc_o
);
    import cpu_pkg::*;

    word_t nextPc;

    always_comb begin
        if (branchTaken_i) begin
            nextPc = branchTarget_i;  // resolved in execute, wins over decode
        end else if (jump_i) begin
            nextPc = jumpTarget_i;
        end else begin
            nextPc = pc_o + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= `RESET_PC;
        end else if (!stall_i) begin
            pc_o <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
    input  wire                     clk,
    input  wire                     reset_i,
    input  wire                     we_i,
    input  wire cpu_pkg::regAddr_t  waddr_i,
    input  wire cpu_pkg::regAddr_t  raddr1_i,
    input  wire cpu_pkg::regAddr_t  raddr2_i,
    input  wire cpu_pkg::word_t     wdata_i,
    output cpu_pkg::word_t          rdata1_o,
    output cpu_pkg::word_t          rdata2_o
);
    import cpu_pkg::*;

    word_t regs [`NUM_REGS];

    // all registers start at zero
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // a write to r0 is kept but never seen
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- rtl/mips_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module mips_pipeline (
    input  wire                       clk,
    input  wire                       reset_i,
    output cpu_pkg::word_t            instAddr_o,
    output logic                      instEn_o,
    input  wire cpu_pkg::word_t       instr_i,
    output logic                      memEn_o,
    output logic                      memWe_o,
    output cpu_pkg::word_t            memAddr_o,
    output cpu_pkg::word_t            memWdata_o,
    input  wire cpu_pkg::word_t       memRdata_i,
    output cpu_pkg::word_t            debugWbPc_o,
    output logic                      debugWbRfWen_o,
    output cpu_pkg::regAddr_t         debugWbRfWnum_o,
    output cpu_pkg::word_t            debugWbRfWdata_o
);
    import cpu_pkg::*;

    logic     stallFd;
    logic     flushD;
    logic     flushE;
    fwdSel_t  fwdA;
    fwdSel_t  fwdB;
    word_t    pcF;

    word_t    pcD;
    word_t    instrD;
    word_t    pcPlus4D;
    imm_t     immFieldD;
    word_t    immD;
    word_t    rfData1D;
    word_t    rfData2D;
    word_t    rsValD;
    word_t    rtValD;
    word_t    srcBD;
    word_t    branchTargetD;
    word_t    jumpTargetD;
    regAddr_t destD;
    aluOp_t   aluOpD;
    logic     useImmD;
    logic     regWriteD;
    logic     memReadD;
    logic     memWriteD;
    logic     branchD;
    logic     branchNeD;
    logic     jumpD;
    logic     readsRsD;
    logic     readsRtD;

    word_t    pcE;
    word_t    rsValE;
    word_t    rtValE;
    word_t    srcBE;
    word_t    branchTargetE;
    word_t    aluResultE;
    regAddr_t destE;
    aluOp_t   aluOpE;
    logic     regWriteE;
    logic     memReadE;
    logic     memWriteE;
    logic     branchE;
    logic     branchNeE;
    logic     branchTakenE;

    word_t    pcM;
    word_t    aluResultM;
    word_t    storeDataM;
    word_t    resultM;
    regAddr_t destM;
    logic     regWriteM;
    logic     memReadM;
    logic     memWriteM;

    word_t    pcW;
    word_t    resultW;
    regAddr_t destW;
    logic     regWriteW;

    function automatic word_t pickOperand(input fwdSel_t sel, input word_t rfVal);
        word_t val;
        case (sel)
            FWD_EXEC: val = aluResultE;
            FWD_MEM:  val = resultM;
            FWD_WB:   val = resultW;
            default:  val = rfVal;
        endcase
        return val;
    endfunction

    pc_unit u_pcUnit (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stallFd),
        .jump_i         (jumpD),
        .jumpTarget_i   (jumpTargetD),
        .branchTaken_i  (branchTakenE),
        .branchTarget_i (branchTargetE),
        .pc_o           (pcF)
    );

    assign instAddr_o = pcF;
    assign instEn_o   = !stallFd;  // held fetch needs no new read

    always_ff @(posedge clk) begin
        if (reset_i || flushD) begin
            instrD <= '0;  // sll r0 decodes as a nop
        end else if (!stallFd) begin
            instrD <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallFd) begin
            pcD <= pcF;
        end
    end

    inst_decoder u_decoder (
        .instr_i    (instrD),
        .aluOp_o    (aluOpD),
        .useImm_o   (useImmD),
        .regWrite_o (regWriteD),
        .destReg_o  (destD),
        .memRead_o  (memReadD),
        .memWrite_o (memWriteD),
        .branch_o   (branchD),
        .branchNe_o (branchNeD),
        .jump_o     (jumpD),
        .readsRs_o  (readsRsD),
        .readsRt_o  (readsRtD)
    );

    reg_file u_regFile (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (regWriteW),
        .waddr_i  (destW),
        .raddr1_i (instrD[25:21]),
        .raddr2_i (instrD[20:16]),
        .wdata_i  (resultW),
        .rdata1_o (rfData1D),
        .rdata2_o (rfData2D)
    );

    assign rsValD = pickOperand(fwdA, rfData1D);
    assign rtValD = pickOperand(fwdB, rfData2D);

    assign immFieldD     = instrD[15:0];
    assign immD          = {{16{immFieldD[15]}}, immFieldD};
    assign srcBD         = useImmD ? immD : rtValD;
    assign pcPlus4D      = pcD + 32'd4;
    assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
    assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};  // region of the slot

    // decode to execute, bubble on load-use
    always_ff @(posedge clk) begin
        if (reset_i || flushE) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
        end else begin
            regWriteE <= regWriteD;
            memReadE  <= memReadD;
            memWriteE <= memWriteD;
            branchE   <= branchD;
        end
    end

    always_ff @(posedge clk) begin
        pcE           <= pcD;
        aluOpE        <= aluOpD;
        branchNeE     <= branchNeD;
        rsValE        <= rsValD;
        rtValE        <= rtValD;
        srcBE         <= srcBD;
        destE         <= destD;
        branchTargetE <= branchTargetD;
    end

    alu u_alu (
        .aluOp_i       (aluOpE),
        .srcA_i        (rsValE),
        .srcB_i        (srcBE),
        .rsVal_i       (rsValE),
        .rtVal_i       (rtValE),
        .branch_i      (branchE),
        .branchNe_i    (branchNeE),
        .result_o      (aluResultE),
        .branchTaken_o (branchTakenE)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        pcM        <= pcE;
        aluResultM <= aluResultE;
        storeDataM <= rtValE;
        destM      <= destE;
    end

    // data memory answers in the same cycle
    assign memEn_o    = memReadM || memWriteM;
    assign memWe_o    = memWriteM;
    assign memAddr_o  = aluResultM;
    assign memWdata_o = storeDataM;
    assign resultM    = memReadM ? memRdata_i : aluResultM;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        pcW     <= pcM;
        resultW <= resultM;
        destW   <= destM;
    end

    hazard_unit u_hazard (
        .rsD_i          (instrD[25:21]),
        .rtD_i          (instrD[20:16]),
        .readsRs_i      (readsRsD),
        .readsRt_i      (readsRtD),
        .destE_i        (destE),
        .destM_i        (destM),
        .destW_i        (destW),
        .regWriteE_i    (regWriteE),
        .regWriteM_i    (regWriteM),
        .regWriteW_i    (regWriteW),
        .memReadE_i     (memReadE),
        .branchTakenE_i (branchTakenE),
        .fwdA_o         (fwdA),
        .fwdB_o         (fwdB),
        .stallFd_o      (stallFd),
        .flushD_o       (flushD),
        .flushE_o       (flushE)
    );

    assign debugWbPc_o      = pcW;
    assign debugWbRfWen_o   = regWriteW;
    assign debugWbRfWnum_o  = destW;
    assign debugWbRfWdata_o = resultW;

endmodule

`default_nettype wire

//--- tb/tb_mips_pipeline.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_defs.svh"

module tb_mips_pipeline;
    import cpu_pkg::*;

    localparam int    RESET_CYCLES   = 8;
    localparam int    PROG_LEN       = 200;
    localparam int    INST_DEPTH     = 256;
    localparam int    DATA_WORDS     = 64;
    localparam int    MAX_EXPECT     = 256;
    localparam int    DRAIN_CYCLES   = 20;
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + 2 * PROG_LEN + 1000;  // one stall each
    localparam word_t INST_BYTES     = 32'd1024;
    localparam word_t SEED           = 32'h11f0_4948;

    logic     clk;
    logic     reset;
    word_t    instAddr;
    logic     instEn;
    word_t    instr;
    logic     memEn;
    logic     memWe;
    word_t    memAddr;
    word_t    memWdata;
    word_t    memRdata;
    word_t    dbgPc;
    logic     dbgWen;
    regAddr_t dbgWnum;
    word_t    dbgWdata;
    word_t    fetchOffset;
    word_t    prevInstAddr;
    logic     prevInstEn;

    word_t    instMem [INST_DEPTH];
    word_t    dataMem [DATA_WORDS];
    word_t    rngState;

    // expected results from the ISA model, in program order
    word_t    expPc [MAX_EXPECT];
    regAddr_t expReg [MAX_EXPECT];
    word_t    expVal [MAX_EXPECT];
    word_t    expStAddr [MAX_EXPECT];
    word_t    expStData [MAX_EXPECT];
    int       numWrites = 0;
    int       numStores = 0;
    int       writeIdx = 0;
    int       storeIdx = 0;
    int       postResetCycles = 0;
    int       cycleCount = 0;

    mips_pipeline u_dut (
        .clk              (clk),
        .reset_i          (reset),
        .instAddr_o       (instAddr),
        .instEn_o         (instEn),
        .instr_i          (instr),
        .memEn_o          (memEn),
        .memWe_o          (memWe),
        .memAddr_o        (memAddr),
        .memWdata_o       (memWdata),
        .memRdata_i       (memRdata),
        .debugWbPc_o      (dbgPc),
        .debugWbRfWen_o   (dbgWen),
        .debugWbRfWnum_o  (dbgWnum),
        .debugWbRfWdata_o (dbgWdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // both memories answer in the same cycle
    assign fetchOffset = instAddr - `RESET_PC;
    assign instr       = (fetchOffset < INST_BYTES) ? instMem[fetchOffset[9:2]] : '0;
    assign memRdata    = dataMem[memAddr[7:2]];

    function automatic word_t fillWord(input int idx);
        word_t addr;
        addr = word_t'(idx) << 2;
        return (addr * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;  // mixes every address bit
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) begin
                dataMem[i] <= fillWord(i);
            end
        end else if (memWe) begin
            dataMem[memAddr[7:2]] <= memWdata;
        end
    end

    function automatic word_t nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState >> 16;  // low LCG bits are weak
    endfunction

    function automatic int instIndex(input word_t addr);
        word_t offset;
        offset = addr - `RESET_PC;
        return int'(offset >> 2);
    endfunction

    function automatic regAddr_t pickSource(input regAddr_t recent);
        word_t    r;
        regAddr_t src;
        r = nextRand();
        if (r[0]) begin
            src = recent;  // seeds a dependent pair
        end else begin
            src = r[5:1];  // r0 included now and then
        end
        return src;
    endfunction

    function automatic regAddr_t pickDest();
        word_t    r;
        regAddr_t dest;
        r = nextRand();
        if (r[1:0] == 2'b00) begin
            dest = regAddr_t'(32'd1 + (r >> 2) % 32'd31);
        end else begin
            dest = regAddr_t'(32'd1 + (r >> 2) % 32'd7);  // small pool, more hazards
        end
        return dest;
    endfunction

    function automatic logic [5:0] pickFunct();
        logic [5:0] fn;
        case (nextRand() % 32'd6)
            32'd0:   fn = `FN_ADDU;
            32'd1:   fn = `FN_SUBU;
            32'd2:   fn = `FN_AND;
            32'd3:   fn = `FN_OR;
            32'd4:   fn = `FN_XOR;
            default: fn = `FN_SLT;
        endcase
        return fn;
    endfunction

    function automatic word_t encodeR(input regAddr_t rs, input regAddr_t rt,
                                      input regAddr_t rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encodeI(input logic [5:0] op, input regAddr_t rs,
                                      input regAddr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encodeJ(input int targetIdx);
        word_t target;
        target = `RESET_PC + word_t'(targetIdx) * 32'd4;
        return {`OP_J, target[27:2]};
    endfunction

    task automatic buildProgram();
        word_t    r;
        int       kind;
        int       offset;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        regAddr_t lastDest;
        logic     prevCtrl;
        rngState = SEED;
        lastDest = 5'd1;
        prevCtrl = 1'b0;
        for (int i = 0; i < INST_DEPTH; i++) begin
            instMem[i] = '0;  // nop tail
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = int'(nextRand() % 32'd16);
            if ((prevCtrl || i == PROG_LEN - 1) && kind >= 12 && kind <= 14) begin
                kind = 6;  // delay slot stays plain
            end
            rs = pickSource(lastDest);
            rt = pickSource(lastDest);
            rd = pickDest();
            r  = nextRand();
            if (kind <= 5) begin
                instMem[i] = encodeR(rs, rt, rd, pickFunct());
                lastDest = rd;
            end else if (kind <= 8) begin
                instMem[i] = encodeI(`OP_ADDIU, rs, rd, r[15:0]);
                lastDest = rd;
            end else if (kind <= 10) begin
                instMem[i] = encodeI(`OP_LW, 5'd0, rd, {8'd0, r[5:0], 2'b00});
                lastDest = rd;  // next reader makes a load-use pair
            end else if (kind == 11) begin
                instMem[i] = encodeI(`OP_SW, 5'd0, rt, {8'd0, r[5:0], 2'b00});
            end else if (kind <= 13) begin
                if (r[12:11] == 2'b00) begin
                    rt = rs;
                end
                offset = 1 + int'(r % 32'd6);
                instMem[i] = encodeI(kind == 12 ? `OP_BEQ : `OP_BNE, rs, rt, 16'(offset));
            end else if (kind == 14) begin
                instMem[i] = encodeJ(i + 2 + int'(r % 32'd6));
            end
            prevCtrl = (kind >= 12 && kind <= 14);
        end
    endtask

    // ISA reference with one delay slot per branch or jump
    task automatic runModel();
        word_t    regs [`NUM_REGS];
        word_t    mem [DATA_WORDS];
        word_t    pc;
        word_t    nextPc;
        word_t    newNext;
        word_t    ir;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    addr;
        word_t    result;
        logic     writes;
        regAddr_t dest;
        int       steps;
        for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            mem[i] = fillWord(i);
        end
        pc     = `RESET_PC;
        nextPc = pc + 32'd4;
        steps  = 0;
        while (instIndex(pc) < PROG_LEN && steps < 4 * PROG_LEN) begin
            ir      = instMem[instIndex(pc)];
            a       = regs[ir[25:21]];
            b       = regs[ir[20:16]];
            imm     = {{16{ir[15]}}, ir[15:0]};
            newNext = nextPc + 32'd4;
            writes  = 1'b0;
            dest    = ir[20:16];
            result  = '0;
            case (ir[31:26])
                `OP_RTYPE: begin
                    dest   = ir[15:11];
                    writes = 1'b1;
                    case (ir[5:0])
                        `FN_ADDU: result = a + b;
                        `FN_SUBU: result = a - b;
                        `FN_AND:  result = a & b;
                        `FN_OR:   result = a | b;
                        `FN_XOR:  result = a ^ b;
                        `FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  writes = 1'b0;
                    endcase
                end
                `OP_ADDIU: begin
                    result = a + imm;
                    writes = 1'b1;
                end
                `OP_LW: begin
                    addr   = a + imm;
                    result = mem[addr[7:2]];
                    writes = 1'b1;
                end
                `OP_SW: begin
                    addr               = a + imm;
                    mem[addr[7:2]]     = b;
                    expStAddr[numStores] = addr;
                    expStData[numStores] = b;
                    numStores++;
                end
                `OP_BEQ: begin
                    if (a == b) begin
                        newNext = pc + 32'd4 + (imm << 2);
                    end
                end
                `OP_BNE: begin
                    if (a != b) begin
                        newNext = pc + 32'd4 + (imm << 2);
                    end
                end
                `OP_J:   newNext = {nextPc[31:28], ir[25:0], 2'b00};  // region of the slot
                default: ;
            endcase
            if (writes) begin
                if (dest != '0) begin
                    regs[dest] = result;
                end
                expPc[numWrites]  = pc;
                expReg[numWrites] = dest;
                expVal[numWrites] = result;
                numWrites++;
            end
            pc     = nextPc;
            nextPc = newNext;
            steps++;
        end
    endtask

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkWord(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic checkReg(input string what, input regAddr_t got, input regAddr_t exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("FAILED at time %0t: %s is r%0d, expected r%0d",
                                      $time, what, got, exp));
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stopWithFailure($sformatf("FAILED at time %0t: %s is %b, expected %b",
                                      $time, what, got, exp));
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            checkFlag("memEn_o in reset", memEn, 1'b0);
            checkFlag("debugWbRfWen_o in reset", dbgWen, 1'b0);
        end else begin
            if (postResetCycles == 0) begin
                checkWord("first fetch address", instAddr, `RESET_PC);
                checkFlag("first fetch enable", instEn, 1'b1);
            end else if (prevInstEn === 1'b0) begin
                // a held fetch keeps its address
                checkWord("held fetch address", instAddr, prevInstAddr);
            end
            prevInstAddr = instAddr;
            prevInstEn   = instEn;
            if (postResetCycles < 3) begin
                checkFlag("memEn_o after reset", memEn, 1'b0);
                checkFlag("debugWbRfWen_o after reset", dbgWen, 1'b0);
            end
            postResetCycles++;
            if (dbgWen === 1'b1) begin
                if (writeIdx >= numWrites) begin
                    stopWithFailure("DUT retired a register write that the program never makes");
                end else begin
                    checkWord("retire pc", dbgPc, expPc[writeIdx]);
                    checkReg("retire register", dbgWnum, expReg[writeIdx]);
                    checkWord("retire value", dbgWdata, expVal[writeIdx]);
                    writeIdx++;
                end
            end
            if (memWe === 1'b1) begin
                if (storeIdx >= numStores) begin
                    stopWithFailure("DUT issued a store that the program never makes");
                end else begin
                    checkFlag("memEn_o with a store", memEn, 1'b1);
                    checkWord("store address", memAddr, expStAddr[storeIdx]);
                    checkWord("store data", memWdata, expStData[storeIdx]);
                    storeIdx++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            stopWithFailure($sformatf("timeout: DUT did not retire the program in %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    initial begin
        reset = 1'b1;
        prevInstAddr = '0;
        prevInstEn   = 1'b1;
        buildProgram();
        runModel();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (writeIdx < numWrites || storeIdx < numStores) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);  // catch stray writes from the nop tail
        if (writeIdx == numWrites && storeIdx == numStores) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stopWithFailure("DUT did not produce every expected write and store");
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/hazard_unit.sv
rtl/inst_decoder.sv
rtl/pc_unit.sv
rtl/reg_file.sv
rtl/mips_pipeline.sv
tb/tb_mips_pipeline.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_mips_pipeline -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
